// File: Makefile
BIN = obj_dir/Vtb_odd_pipe
SRCS = sources.f $(wildcard src/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_odd_pipe -Mdir obj_dir

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: sources.f
src/odd_pkg.sv
src/odd_decode.sv
src/permute_unit.sv
src/branch_unit.sv
src/ls_unit.sv
src/ls_arbiter.sv
src/local_store.sv
src/odd_pipe.sv
test/odd_pipe_assertions.sv
test/tb_odd_pipe.sv

// File: src/branch_unit.sv
`timescale 1ns/100ps

module branch_unit import odd_pkg::*; (
  input logic clk,
  input logic rst,
  input dec_t dec,
  input operands_t operands,
  input logic [pc_w-1:0] pc,
  output qword_t link,
  output branch_t branch
);

  logic taken;
  logic rc_zero;
  logic [pc_w-1:0] target;
  logic [pc_w-1:0] pc_next;

  assign rc_zero = operands.rc[qword_w-1 -: 32] == 32'd0;   // word 0 of rt
  assign pc_next = pc + 1'b1;
  assign target = pc + dec.imm16[pc_w-1:0];                 // word offset, wraps
  assign link = {{(32 - pc_w){1'b0}}, pc_next, {(qword_w - 32){1'b0}}};

  always_comb begin
    case (dec.op)
      fn_br, fn_brsl: taken = 1'b1;
      fn_brz:         taken = rc_zero;
      fn_brnz:        taken = !rc_zero;
      default:        taken = 1'b0;
    endcase
  end

  // outcome seen by fetch one cycle after issue
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      branch <= '0;
    end else begin
      branch.taken <= taken;
      branch.new_pc <= taken ? target : pc_next;
    end
  end

endmodule

// File: src/local_store.sv
`timescale 1ns/100ps

module local_store import odd_pkg::*; (
  input logic clk,
  input ls_req_t mem_req,
  output qword_t rdata
);

  qword_t mem [ls_qwords];

  // single port, one access per cycle
  always_ff @(posedge clk) begin
    if (mem_req.valid) begin
      if (mem_req.we) begin
        mem[mem_req.idx] <= mem_req.wdata;
      end else begin
        rdata <= mem[mem_req.idx];   // ready the cycle after the request
      end
    end
  end

endmodule

// File: src/ls_arbiter.sv
`timescale 1ns/100ps

module ls_arbiter import odd_pkg::*; (
  input logic clk,
  input logic rst,
  input ls_req_t ls_req,
  input dma_req_t dma_req,
  output logic dma_credit,
  output dma_rsp_t dma_rsp,
  output ls_req_t mem_req,
  input qword_t mem_rdata
);

  dma_req_t q_mem [dma_credits];   // one slot per credit
  logic [dma_ptr_w-1:0] wr_ptr;
  logic [dma_ptr_w-1:0] rd_ptr;
  logic [dma_ptr_w:0] count;
  logic dma_grant;
  logic dma_grant_q;   // last cycle's port went to DMA

  // pipeline side always wins, DMA takes idle cycles
  assign dma_grant = !ls_req.valid && (count != '0);

  always_comb begin
    mem_req = ls_req;
    if (!ls_req.valid) begin
      mem_req = ls_req_t'(q_mem[rd_ptr]);
      mem_req.valid = dma_grant;
    end
  end

  always_ff @(posedge clk) begin
    if (dma_req.valid) begin
      q_mem[wr_ptr] <= dma_req;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      dma_grant_q <= 1'b0;
    end else begin
      if (dma_req.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (dma_grant) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({dma_req.valid, dma_grant})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      dma_grant_q <= dma_grant;
    end
  end

  // slot freed and read data back in the same cycle
  assign dma_credit = dma_grant_q;
  assign dma_rsp = '{valid: dma_grant_q, rdata: mem_rdata};

endmodule

// File: src/ls_unit.sv
`timescale 1ns/100ps

module ls_unit import odd_pkg::*; (
  input dec_t dec,
  input operands_t operands,
  output ls_req_t req
);

  logic [31:0] addr;
  logic [ls_addr_w-1:0] byte_addr;
  logic d_form;

  assign d_form = (dec.op == fn_lqd) || (dec.op == fn_stqd);

  // d-form is ra relative, a-form is absolute
  always_comb begin
    if (d_form) begin
      addr = operands.ra[qword_w-1 -: 32] + (dec.imm10 << 4);
    end else begin
      addr = dec.imm16 << 2;
    end
  end

  assign byte_addr = addr[ls_addr_w-1:0];   // wraps inside the local store

  always_comb begin
    req.valid = dec.unit == unit_ls;
    req.we = (dec.op == fn_stqd) || (dec.op == fn_stqa);
    req.idx = byte_addr[ls_addr_w-1 -: ls_idx_w];
    req.wdata = operands.rc;   // store data
  end

endmodule

// File: src/odd_decode.sv
`timescale 1ns/100ps

module odd_decode import odd_pkg::*; (
  input instr_u instr,
  input logic issue_valid,
  output dec_t dec
);

  always_comb begin
    dec = '0;
    dec.rt = instr.rr.rt;   // same position in rr, ri10 and ri16
    dec.imm10 = {{22{instr.ri10.i10[9]}}, instr.ri10.i10};
    dec.imm16 = {{16{instr.ri16.i16[15]}}, instr.ri16.i16};
    dec.imm7 = instr.rr.rb;

    // pick the operation, widest opcode formats checked by their own view
    if (issue_valid) begin
      if (instr.rrr.op == op_shufb) begin
        dec.op = fn_shufb;
        dec.rt = instr.rrr.rt;  // rrr keeps rt right after the opcode
      end else if (instr.rr.op == op_rotqbyi) begin
        dec.op = fn_rotqbyi;
      end else if (instr.rr.op == op_shlqbyi) begin
        dec.op = fn_shlqbyi;
      end else if (instr.ri10.op == op_lqd) begin
        dec.op = fn_lqd;
      end else if (instr.ri10.op == op_stqd) begin
        dec.op = fn_stqd;
      end else begin
        case (instr.ri16.op)
          op_lqa:  dec.op = fn_lqa;
          op_stqa: dec.op = fn_stqa;
          op_br:   dec.op = fn_br;
          op_brsl: dec.op = fn_brsl;
          op_brz:  dec.op = fn_brz;
          op_brnz: dec.op = fn_brnz;
          default: dec.op = fn_nop;
        endcase
      end
    end

    // unit, write flag and latency follow from the operation
    case (dec.op)
      fn_shufb, fn_rotqbyi, fn_shlqbyi: begin
        dec.unit = unit_perm;
        dec.reg_wr = 1'b1;
        dec.latency = lat_perm;
      end
      fn_lqd, fn_lqa: begin
        dec.unit = unit_ls;
        dec.reg_wr = 1'b1;
        dec.latency = lat_load;
      end
      fn_stqd, fn_stqa: begin
        dec.unit = unit_ls;     // no register write
        dec.latency = lat_load;
      end
      fn_brsl: begin
        dec.unit = unit_br;
        dec.reg_wr = 1'b1;      // link into rt
        dec.latency = lat_branch;
      end
      fn_br, fn_brz, fn_brnz: begin
        dec.unit = unit_br;
        dec.latency = lat_branch;
      end
      default: dec.unit = unit_none;
    endcase
  end

endmodule

// File: src/odd_pipe.sv
`timescale 1ns/100ps

module odd_pipe import odd_pkg::*; (
  input logic clk,
  input logic rst,
  input logic issue_valid,
  input instr_u instr,
  input operands_t operands,
  input logic [pc_w-1:0] pc,
  input dma_req_t dma_req,
  output result_t stages [1:result_stages],   // forwarding taps
  output wb_t wb,
  output branch_t branch,
  output logic dma_credit,
  output dma_rsp_t dma_rsp
);

  dec_t dec;
  qword_t perm_data;
  qword_t link_data;
  ls_req_t ls_req;
  ls_req_t mem_req;
  qword_t mem_rdata;
  result_t stage0;
  logic stage1_load;

  odd_decode u_decode (
    .instr(instr),
    .issue_valid(issue_valid),
    .dec(dec)
  );

  permute_unit u_perm (
    .dec(dec),
    .operands(operands),
    .result(perm_data)
  );

  branch_unit u_branch (
    .clk(clk),
    .rst(rst),
    .dec(dec),
    .operands(operands),
    .pc(pc),
    .link(link_data),
    .branch(branch)
  );

  ls_unit u_ls (
    .dec(dec),
    .operands(operands),
    .req(ls_req)
  );

  ls_arbiter u_arb (
    .clk(clk),
    .rst(rst),
    .ls_req(ls_req),
    .dma_req(dma_req),
    .dma_credit(dma_credit),
    .dma_rsp(dma_rsp),
    .mem_req(mem_req),
    .mem_rdata(mem_rdata)
  );

  local_store u_store (
    .clk(clk),
    .mem_req(mem_req),
    .rdata(mem_rdata)
  );

  // stage 0 packer
  always_comb begin
    stage0.unit = dec.unit;
    stage0.rt = dec.rt;
    stage0.latency = dec.latency;
    stage0.reg_wr = dec.reg_wr;
    case (dec.unit)
      unit_perm: stage0.data = perm_data;
      unit_br:   stage0.data = link_data;
      unit_ls:   stage0.data = operands.rc;   // store data visible to forwarding
      default:   stage0.data = '0;
    endcase
  end

  // stores carry no write, so this picks loads only
  assign stage1_load = (stages[1].unit == unit_ls) && stages[1].reg_wr;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i <= result_stages; i++) begin
        stages[i] <= '0;
      end
      wb <= '0;
    end else begin
      stages[1] <= stage0;
      stages[2] <= stages[1];
      if (stage1_load) begin
        stages[2].data <= mem_rdata;   // read data arrives while in stage 1
      end
      for (int i = 3; i <= result_stages; i++) begin
        stages[i] <= stages[i - 1];
      end
      wb.en <= stages[result_stages].reg_wr;
      wb.addr <= stages[result_stages].rt;
      wb.data <= stages[result_stages].data;
    end
  end

endmodule

// File: src/odd_pkg.sv
package odd_pkg;

  localparam int qword_w = 128;
  localparam int ls_qwords = 2048;
  localparam int ls_addr_w = 15;                  // local-store byte address
  localparam int ls_idx_w = $clog2(ls_qwords);    // quadword index, upper bits of address
  localparam int pc_w = 10;                       // word address
  localparam int dma_credits = 2;
  localparam int dma_ptr_w = $clog2(dma_credits); // queue pointer, depth is a power of two
  localparam int result_stages = 7;

  localparam logic [3:0] lat_perm = 4'd4;
  localparam logic [3:0] lat_load = 4'd6;
  localparam logic [3:0] lat_branch = 4'd2;

  // RI10 forms
  localparam logic [7:0] op_lqd = 8'b00110100;
  localparam logic [7:0] op_stqd = 8'b00100100;
  // RI16 forms
  localparam logic [8:0] op_lqa = 9'b001100001;
  localparam logic [8:0] op_stqa = 9'b001000001;
  localparam logic [8:0] op_br = 9'b001100100;
  localparam logic [8:0] op_brsl = 9'b001100110;
  localparam logic [8:0] op_brz = 9'b001000000;
  localparam logic [8:0] op_brnz = 9'b001000010;
  // RRR form
  localparam logic [3:0] op_shufb = 4'b1011;
  // RI7 in the RR layout
  localparam logic [10:0] op_rotqbyi = 11'b00111111100;
  localparam logic [10:0] op_shlqbyi = 11'b00111111111;

  typedef logic [qword_w-1:0] qword_t;

  typedef enum logic [1:0] {
    unit_none,
    unit_perm,
    unit_ls,
    unit_br
  } unit_e;

  // internal operation, one per supported instruction
  typedef enum logic [3:0] {
    fn_nop,
    fn_lqd,
    fn_stqd,
    fn_lqa,
    fn_stqa,
    fn_shufb,
    fn_rotqbyi,
    fn_shlqbyi,
    fn_br,
    fn_brsl,
    fn_brz,
    fn_brnz
  } fn_e;

  typedef struct packed {
    logic [10:0] op;
    logic [6:0] rb;   // i7 for the RI7 forms
    logic [6:0] ra;
    logic [6:0] rt;
  } rr_t;

  typedef struct packed {
    logic [3:0] op;
    logic [6:0] rt;
    logic [6:0] rb;
    logic [6:0] ra;
    logic [6:0] rc;
  } rrr_t;

  typedef struct packed {
    logic [7:0] op;
    logic [9:0] i10;
    logic [6:0] ra;
    logic [6:0] rt;
  } ri10_t;

  typedef struct packed {
    logic [8:0] op;
    logic [15:0] i16;
    logic [6:0] rt;
  } ri16_t;

  // one instruction word, read through every format at decode
  typedef union packed {
    rr_t rr;
    rrr_t rrr;
    ri10_t ri10;
    ri16_t ri16;
  } instr_u;

  typedef struct packed {
    unit_e unit;
    fn_e op;
    logic [6:0] rt;
    logic reg_wr;
    logic [3:0] latency;
    logic [31:0] imm10;   // sign-extended
    logic [31:0] imm16;   // sign-extended
    logic [6:0] imm7;
  } dec_t;

  typedef struct packed {
    qword_t ra;
    qword_t rb;
    qword_t rc;   // rt value for stores and conditional branches
  } operands_t;

  typedef struct packed {
    unit_e unit;
    qword_t data;
    logic [6:0] rt;
    logic [3:0] latency;
    logic reg_wr;
  } result_t;

  typedef struct packed {
    logic en;
    logic [6:0] addr;
    qword_t data;
  } wb_t;

  typedef struct packed {
    logic taken;
    logic [pc_w-1:0] new_pc;
  } branch_t;

  typedef struct packed {
    logic valid;
    logic we;
    logic [ls_idx_w-1:0] idx;
    qword_t wdata;
  } ls_req_t;

  typedef struct packed {
    logic valid;
    logic we;
    logic [ls_idx_w-1:0] idx;
    qword_t wdata;
  } dma_req_t;

  typedef struct packed {
    logic valid;
    qword_t rdata;
  } dma_rsp_t;

endpackage

// File: src/permute_unit.sv
`timescale 1ns/100ps

module permute_unit import odd_pkg::*; (
  input dec_t dec,
  input operands_t operands,
  output qword_t result
);

  // packed byte k sits at byte position 15-k, so byte 0 is the top byte
  function automatic qword_t shuffle(qword_t ra, qword_t rb, qword_t rc);
    logic [31:0][7:0] cat;
    logic [15:0][7:0] ctl;
    logic [15:0][7:0] res;
    cat = {ra, rb};
    ctl = rc;
    for (int k = 0; k < 16; k++) begin
      casez (ctl[k])
        8'b10??????: res[k] = 8'h00;
        8'b110?????: res[k] = 8'hff;
        8'b111?????: res[k] = 8'h80;
        default:     res[k] = cat[5'd31 - ctl[k][4:0]];
      endcase
    end
    return res;
  endfunction

  function automatic qword_t rotate_bytes(qword_t ra, logic [3:0] n);
    logic [15:0][7:0] src;
    logic [15:0][7:0] res;
    logic [3:0] j;
    src = ra;
    for (int i = 0; i < 16; i++) begin
      j = 4'(i) + n;          // wraps mod 16
      res[15 - i] = src[4'd15 - j];
    end
    return res;
  endfunction

  function automatic qword_t shift_bytes(qword_t ra, logic [4:0] n);
    logic [15:0][7:0] src;
    logic [15:0][7:0] res;
    logic [5:0] j;
    src = ra;
    for (int i = 0; i < 16; i++) begin
      j = 6'(i) + 6'(n);
      res[15 - i] = (j < 6'd16) ? src[4'd15 - j[3:0]] : 8'h00;  // zero fill
    end
    return res;
  endfunction

  always_comb begin
    case (dec.op)
      fn_shufb:   result = shuffle(operands.ra, operands.rb, operands.rc);
      fn_rotqbyi: result = rotate_bytes(operands.ra, dec.imm7[3:0]);
      fn_shlqbyi: result = shift_bytes(operands.ra, dec.imm7[4:0]);
      default:    result = '0;
    endcase
  end

endmodule

// File: test/odd_pipe_assertions.sv
`timescale 1ns/100ps

module odd_pipe_assertions (
  input logic clk,
  input logic rst,
  input logic wb_en,
  input logic dma_req_valid,
  input logic dma_credit,
  input logic dma_grant,
  input logic dma_rsp_valid
);

  int pending;   // DMA requests sent and not yet credited back

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pending <= 0;
    end else begin
      pending <= pending + int'(dma_req_valid) - int'(dma_credit);
    end
  end

  // write-back stays quiet through reset
  wb_quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !wb_en)
    else $error("write-back enabled during reset");

  credit_needs_pending: assert property (
    @(posedge clk) disable iff (rst) dma_credit |-> pending > 0)
    else $error("DMA credit returned with no request pending");

  grant_gives_rsp: assert property (
    @(posedge clk) disable iff (rst) dma_grant |=> dma_rsp_valid)
    else $error("DMA grant not followed by a response");

endmodule

// a DMA grant is a memory request with no load/store request
bind odd_pipe odd_pipe_assertions u_assert (
  .clk(clk),
  .rst(rst),
  .wb_en(wb.en),
  .dma_req_valid(dma_req.valid),
  .dma_credit(dma_credit),
  .dma_grant(mem_req.valid && !ls_req.valid),
  .dma_rsp_valid(dma_rsp.valid)
);

// File: test/tb_odd_pipe.sv
`timescale 1ns/100ps

module tb_odd_pipe import odd_pkg::*; ();

  localparam int n_perm = 60;
  localparam int n_ls = 30;
  localparam int n_mix = 20;
  localparam int n_br = 40;
  localparam int n_dma = 4;
  localparam int n_flood = 12;
  localparam int n_undef = 20;
  localparam int drain_max = 200;
  // every test plus its flush and the DMA drains, with margin
  localparam int max_cycles = 2 * (2 + n_perm + 32 + 2 * n_ls + n_mix + n_br + n_flood
                                   + n_undef + 2 * drain_max + 8 * 12);

  logic clk = 1'b0;
  logic rst;
  logic issue_valid;
  instr_u instr;
  operands_t operands;
  logic [pc_w-1:0] pc;
  dma_req_t dma_req;
  result_t stages [1:result_stages];
  wb_t wb;
  branch_t branch;
  logic dma_credit;
  dma_rsp_t dma_rsp;

  integer seed = 32'hc392e2ad;
  int errors = 0;
  int checks = 0;
  int credits;
  qword_t shadow [ls_qwords];   // expected local-store contents
  wb_t wb_q [$];
  branch_t br_q [$];
  logic br_chk_q [$];
  result_t st_q [$];
  dma_req_t dma_pend [$];
  dma_rsp_t dma_exp [$];
  logic dma_rd_q [$];

  odd_pipe uut (
    .clk(clk),
    .rst(rst),
    .issue_valid(issue_valid),
    .instr(instr),
    .operands(operands),
    .pc(pc),
    .dma_req(dma_req),
    .stages(stages),
    .wb(wb),
    .branch(branch),
    .dma_credit(dma_credit),
    .dma_rsp(dma_rsp)
  );

  always #50 clk = !clk;

  function automatic qword_t rand_q();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // byte 0 is the most significant byte
  function automatic logic [7:0] byte_of(qword_t q, logic [3:0] k);
    return q[127 - 8 * int'(k) -: 8];
  endfunction

  function automatic fn_e ref_decode(instr_u i, logic v);
    if (!v) return fn_nop;
    if (i.rrr.op == op_shufb) return fn_shufb;
    if (i.rr.op == op_rotqbyi) return fn_rotqbyi;
    if (i.rr.op == op_shlqbyi) return fn_shlqbyi;
    if (i.ri10.op == op_lqd) return fn_lqd;
    if (i.ri10.op == op_stqd) return fn_stqd;
    case (i.ri16.op)
      op_lqa:  return fn_lqa;
      op_stqa: return fn_stqa;
      op_br:   return fn_br;
      op_brsl: return fn_brsl;
      op_brz:  return fn_brz;
      op_brnz: return fn_brnz;
      default: return fn_nop;
    endcase
  endfunction

  function automatic logic [ls_idx_w-1:0] ref_index(instr_u i, operands_t o, fn_e f);
    logic [31:0] a;
    if (f == fn_lqd || f == fn_stqd)
      a = o.ra[127 -: 32] + ({{22{i.ri10.i10[9]}}, i.ri10.i10} << 4);
    else
      a = {{16{i.ri16.i16[15]}}, i.ri16.i16} << 2;
    return a[14:4];
  endfunction

  function automatic qword_t ref_perm(instr_u i, operands_t o, fn_e f);
    qword_t r;
    logic [7:0] c;
    logic [7:0] b;
    int n;
    r = '0;
    for (int k = 0; k < 16; k++) begin
      b = 8'h00;
      if (f == fn_shufb) begin
        c = byte_of(o.rc, 4'(k));
        if (c[7:6] == 2'b10) b = 8'h00;
        else if (c[7:5] == 3'b110) b = 8'hff;
        else if (c[7:5] == 3'b111) b = 8'h80;
        else b = c[4] ? byte_of(o.rb, c[3:0]) : byte_of(o.ra, c[3:0]);
      end else if (f == fn_rotqbyi) begin
        n = int'(i.rr.rb[3:0]);
        b = byte_of(o.ra, 4'((k + n) % 16));
      end else begin
        n = int'(i.rr.rb[4:0]);
        if (k + n < 16) b = byte_of(o.ra, 4'(k + n));
      end
      r[127 - 8 * k -: 8] = b;
    end
    return r;
  endfunction

  // expected write-back for one issued instruction
  function automatic wb_t ref_wb(instr_u i, operands_t o, logic [pc_w-1:0] p, logic v);
    wb_t w;
    fn_e f;
    f = ref_decode(i, v);
    w = '0;
    case (f)
      fn_shufb: w = '{en: 1'b1, addr: i.rrr.rt, data: ref_perm(i, o, f)};
      fn_rotqbyi, fn_shlqbyi: w = '{en: 1'b1, addr: i.rr.rt, data: ref_perm(i, o, f)};
      fn_lqd, fn_lqa: w = '{en: 1'b1, addr: i.rr.rt, data: shadow[ref_index(i, o, f)]};
      fn_brsl: w = '{en: 1'b1, addr: i.rr.rt, data: {22'd0, p + 10'd1, 96'd0}};
      default: w = '0;
    endcase
    return w;
  endfunction

  function automatic branch_t ref_branch(instr_u i, operands_t o, logic [pc_w-1:0] p, fn_e f);
    branch_t b;
    logic zero;
    zero = o.rc[127 -: 32] == 32'd0;
    b.taken = (f == fn_br) || (f == fn_brsl) || (f == fn_brz && zero) || (f == fn_brnz && !zero);
    b.new_pc = b.taken ? p + i.ri16.i16[pc_w-1:0] : p + 10'd1;
    return b;
  endfunction

  function automatic result_t ref_stage(instr_u i, fn_e f);
    result_t s;
    s = '0;
    s.rt = (f == fn_shufb) ? i.rrr.rt : i.rr.rt;
    case (f)
      fn_shufb, fn_rotqbyi, fn_shlqbyi: begin
        s.unit = unit_perm;
        s.latency = 4'd4;
        s.reg_wr = 1'b1;
      end
      fn_lqd, fn_lqa, fn_stqd, fn_stqa: begin
        s.unit = unit_ls;
        s.latency = 4'd6;
        s.reg_wr = (f == fn_lqd) || (f == fn_lqa);
      end
      fn_br, fn_brsl, fn_brz, fn_brnz: begin
        s.unit = unit_br;
        s.latency = 4'd2;
        s.reg_wr = f == fn_brsl;
      end
      default: s = '0;
    endcase
    return s;
  endfunction

  task automatic check_wb(wb_t got, wb_t exp);
    checks++;
    if (got.en !== exp.en || (exp.en && (got.addr !== exp.addr || got.data !== exp.data))) begin
      errors++;
      $display("ERR %0t: wb en=%0b addr=%0d data=%h, expected en=%0b addr=%0d data=%h",
               $time, got.en, got.addr, got.data, exp.en, exp.addr, exp.data);
    end
  endtask

  task automatic check_branch(branch_t got, branch_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: branch taken=%0b pc=%0d, expected taken=%0b pc=%0d",
               $time, got.taken, got.new_pc, exp.taken, exp.new_pc);
    end
  endtask

  task automatic check_dma(dma_rsp_t got, dma_rsp_t exp, logic with_data);
    checks++;
    if (got.valid !== exp.valid || (with_data && got.rdata !== exp.rdata)) begin
      errors++;
      $display("ERR %0t: dma rsp valid=%0b data=%h, expected valid=%0b data=%h",
               $time, got.valid, got.rdata, exp.valid, exp.rdata);
    end
  endtask

  task automatic check_stage(result_t got, result_t exp, int n);
    checks++;
    if (got.reg_wr !== exp.reg_wr || got.unit !== exp.unit ||
        (exp.unit != unit_none && (got.rt !== exp.rt || got.latency !== exp.latency))) begin
      errors++;
      $display("ERR %0t: stage %0d unit=%0d rt=%0d lat=%0d wr=%0b, expected %0d %0d %0d %0b",
               $time, n, got.unit, got.rt, got.latency, got.reg_wr,
               exp.unit, exp.rt, exp.latency, exp.reg_wr);
    end
  endtask

  // one issue cycle, plus a DMA send when a credit is held
  task automatic step(logic v, instr_u i, operands_t o, logic [pc_w-1:0] p);
    dma_req_t d;
    dma_rsp_t r;
    fn_e f;
    @(posedge clk);
    issue_valid <= v;
    instr <= i;
    operands <= o;
    pc <= p;
    d = '0;
    if (dma_pend.size() > 0 && credits > 0) begin
      d = dma_pend.pop_front();
      d.valid = 1'b1;
      credits--;
      if (d.we) shadow[d.idx] = d.wdata;
      r = '{valid: 1'b1, rdata: shadow[d.idx]};
      dma_exp.push_back(r);
      dma_rd_q.push_back(!d.we);
    end
    dma_req <= d;
    f = ref_decode(i, v);
    wb_q.push_back(ref_wb(i, o, p, v));
    br_q.push_back(ref_branch(i, o, p, f));
    br_chk_q.push_back(f inside {fn_br, fn_brsl, fn_brz, fn_brnz});
    st_q.push_back(ref_stage(i, f));
    if (f == fn_stqd || f == fn_stqa) shadow[ref_index(i, o, f)] = o.rc;
  endtask

  task automatic idle(int n);
    repeat (n) step(1'b0, '0, '0, '0);
  endtask

  // load or store aimed at a chosen quadword index
  task automatic make_ls(logic store, logic aform, logic [10:0] idx,
                         output instr_u i, output operands_t o);
    logic [31:0] r;
    logic [31:0] r2;
    logic [14:0] base;
    r = $random(seed);
    r2 = $random(seed);
    o = '{ra: rand_q(), rb: rand_q(), rc: rand_q()};
    if (aform) begin
      i = {store ? op_stqa : op_lqa, r[15:13], idx, r[9:8], r[6:0]};
    end else begin
      base = {idx, 4'b0} - 15'({{22{r[25]}}, r[25:16]} << 4) + 15'(r2[3:0]);
      o.ra[127 -: 32] = {r2[31:15], base};
      i = {store ? op_stqd : op_lqd, r[25:16], r[13:7], r[6:0]};
    end
  endtask

  task automatic drain_dma();
    int n;
    n = 0;
    while ((dma_pend.size() > 0 || dma_exp.size() > 0) && n < drain_max) begin
      idle(1);
      n++;
    end
    if (dma_pend.size() > 0 || dma_exp.size() > 0) begin
      errors++;
      $display("DMA requests still waiting for a response after %0d cycles", drain_max);
    end
  endtask

  task automatic queue_dma(logic [10:0] base);
    for (int k = 0; k < n_dma; k++)
      dma_pend.push_back('{valid: 1'b1, we: 1'b1, idx: base + 11'(k), wdata: rand_q()});
    for (int k = 0; k < n_dma; k++)
      dma_pend.push_back('{valid: 1'b1, we: 1'b0, idx: base + 11'(k), wdata: '0});
  endtask

  // compare process, sampled away from the driving edge
  always @(negedge clk) begin
    while (wb_q.size() > 8) check_wb(wb, wb_q.pop_front());
    while (br_q.size() > 1) begin
      if (br_chk_q.pop_front()) check_branch(branch, br_q.pop_front());
      else void'(br_q.pop_front());
    end
    if (st_q.size() > result_stages) begin
      for (int n = 1; n <= result_stages; n++)
        check_stage(stages[n], st_q[st_q.size() - 1 - n], n);
      while (st_q.size() > result_stages + 1) void'(st_q.pop_front());
    end
    if (dma_credit) begin
      credits++;
      if (credits > dma_credits) begin
        errors++;
        $display("DMA credit returned with no request outstanding");
      end
    end
    if (dma_rsp.valid) begin
      if (dma_exp.size() == 0) begin
        errors++;
        $display("unexpected DMA response");
      end else begin
        check_dma(dma_rsp, dma_exp.pop_front(), dma_rd_q.pop_front());
      end
    end
  end

  initial begin
    #(max_cycles * 100);
    $display("timeout after %0d cycles", max_cycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    instr_u i;
    operands_t o;
    logic [31:0] r;
    logic [10:0] a;
    int e0;
    rst = 1'b1;
    issue_valid = 1'b0;
    instr = '0;
    operands = '0;
    pc = '0;
    dma_req = '0;
    credits = dma_credits;
    idle(2);
    rst <= 1'b0;

    e0 = errors;
    for (int k = 0; k < n_perm; k++) begin
      r = $random(seed);
      o = '{ra: rand_q(), rb: rand_q(), rc: rand_q()};
      case (r[31:30] % 3)
        0: i = {op_shufb, r[27:0]};
        1: i = {op_rotqbyi, r[20:0]};
        default: i = {op_shlqbyi, r[20:0]};
      endcase
      step(1'b1, i, o, '0);
    end
    idle(10);
    $display("test 1 permute: %0d errors", errors - e0);

    e0 = errors;
    for (int k = 0; k < 32; k++) begin
      make_ls(1'b1, 1'b1, 11'(k), i, o);
      step(1'b1, i, o, '0);
    end
    for (int k = 0; k < n_ls; k++) begin
      r = $random(seed);
      a = {6'd0, r[4:0]};
      make_ls(1'b1, r[5], a, i, o);
      step(1'b1, i, o, '0);
      make_ls(1'b0, r[6], r[7] ? a : {6'd0, r[12:8]}, i, o);   // same or other address
      step(1'b1, i, o, '0);
    end
    idle(10);
    $display("test 2 load/store: %0d errors", errors - e0);

    e0 = errors;
    for (int k = 0; k < n_mix; k++) begin
      r = $random(seed);
      o = '{ra: rand_q(), rb: rand_q(), rc: rand_q()};
      case (r[1:0])
        0: i = {op_shufb, r[31:4]};
        1: make_ls(1'b0, r[2], {6'd0, r[8:4]}, i, o);
        2: i = {op_brsl, r[31:9]};
        default: i = '0;
      endcase
      step(1'b1, i, o, pc_w'(r[31:22]));
    end
    idle(10);
    $display("test 3 stage taps: %0d errors", errors - e0);

    e0 = errors;
    for (int k = 0; k < n_br; k++) begin
      r = $random(seed);
      o = '{ra: rand_q(), rb: rand_q(), rc: rand_q()};
      if (r[2]) o.rc[127 -: 32] = 32'd0;
      case (r[1:0])
        0: i = {op_br, r[31:9]};
        1: i = {op_brsl, r[31:9]};
        2: i = {op_brz, r[31:9]};
        default: i = {op_brnz, r[31:9]};
      endcase
      step(1'b1, i, o, pc_w'($random(seed)));
    end
    idle(10);
    $display("test 4 branch: %0d errors", errors - e0);

    e0 = errors;
    queue_dma(11'd1024);
    drain_dma();
    queue_dma(11'd1100);
    idle(1);
    for (int k = 0; k < n_flood; k++) begin   // port busy every cycle
      make_ls(1'b1, k[0], 11'(k), i, o);
      step(1'b1, i, o, '0);
    end
    drain_dma();
    if (credits != dma_credits) begin
      errors++;
      $display("DMA credits not all returned, %0d held", credits);
    end
    idle(10);
    $display("test 5 DMA: %0d errors", errors - e0);

    e0 = errors;
    for (int k = 0; k < n_undef; k++) begin
      r = $random(seed);
      if (k % 2 == 0) step(1'b0, r, '{ra: rand_q(), rb: rand_q(), rc: rand_q()}, '0);
      else step(1'b1, r[0] ? 32'hffffffff : 32'h0, '0, '0);
    end
    idle(10);
    $display("test 6 nop: %0d errors", errors - e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
